// File: source/sched_pkg.sv
/*
 * Shared widths, unit latencies, register address and latency types,
 * and the execution unit select encoding for the issue scheduler
 */

`default_nettype none

package sched_pkg;

    //==============================
    // Register file
    //==============================

    // Architectural register index width
    localparam int unsigned REG_ADDR_W = 5;

    // Register 0 is hardwired and never produces a hazard
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //==============================
    // Latencies
    //==============================

    // Wide enough to hold the divider latency plus bypass
    localparam int unsigned LATENCY_W = 6;

    // Cycles left before a unit writes back
    typedef logic [LATENCY_W-1:0] latency_t;

    // The bypass stage adds one cycle to every incoming latency
    localparam int unsigned BYPASS_STAGES = 1;

    // ALU also covers CSR operations
    localparam int unsigned ALU_LATENCY = 1;
    localparam int unsigned MUL_LATENCY = 6;
    localparam int unsigned DIV_LATENCY = 36;

    //==============================
    // Unit select
    //==============================

    // Unit targeted by the instruction waiting to issue
    typedef enum logic [2:0] {
        UNIT_NONE = 3'd0,
        UNIT_ALU  = 3'd1,
        UNIT_MUL  = 3'd2,
        UNIT_DIV  = 3'd3,
        UNIT_LDU  = 3'd4
    } exec_unit_e;

endpackage

`default_nettype wire

// File: source/exec_latency_tracker.sv
/*
 * Single in-flight slot with write-back countdown, stored destination
 * and the RAW and write-back collision compares
 */

`timescale 1ns/1ps
`default_nettype none

module exec_latency_tracker #(
    parameter int unsigned LATENCY = sched_pkg::MUL_LATENCY
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                advance_i,
    input  logic                start_i,
    input  sched_pkg::reg_addr_t src0_i,
    input  sched_pkg::reg_addr_t src1_i,
    input  sched_pkg::reg_addr_t dest_i,
    input  sched_pkg::latency_t  latency_i,
    output logic                raw_hazard_o,
    output logic                latency_hazard_o,
    output logic                busy_o
);

    //==============================
    // Slot state
    //==============================

    sched_pkg::latency_t  cnt_q;
    sched_pkg::reg_addr_t dest_q;

    logic load;

    // Dispatch edge for this slot
    assign load = start_i & advance_i;

    // Countdown to write-back
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= sched_pkg::latency_t'(LATENCY);
        end else if (advance_i && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Destination captured with the counter
    always_ff @(posedge clk_i) begin
        if (load) begin
            dest_q <= dest_i;
        end
    end

    //==============================
    // Hazard compares
    //==============================

    assign busy_o = (cnt_q != '0);

    // RAW on any register field of the waiting instruction
    // Register 0 is excluded
    assign raw_hazard_o = busy_o && (dest_q != '0) &&
                          ((src0_i == dest_q) || (src1_i == dest_q) || (dest_i == dest_q));

    // Two results would land on the write-back port in the same cycle
    assign latency_hazard_o = busy_o && (cnt_q == latency_i);

    // Counter stays within the unit latency
    a_cnt_bound: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cnt_q <= LATENCY
    );

endmodule

`default_nettype wire

// File: source/mul_stage_tracker.sv
/*
 * Pipelined multiplier tracking with one slot per stage
 * selected through a rotating one-hot stage pointer
 */

`timescale 1ns/1ps
`default_nettype none

module mul_stage_tracker (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                advance_i,
    input  logic                start_i,
    input  sched_pkg::reg_addr_t src0_i,
    input  sched_pkg::reg_addr_t src1_i,
    input  sched_pkg::reg_addr_t dest_i,
    input  sched_pkg::latency_t  latency_i,
    output logic                raw_hazard_o,
    output logic                latency_hazard_o,
    output logic                busy_o
);

    localparam int unsigned STAGES = sched_pkg::MUL_LATENCY;

    //==============================
    // Stage pointer
    //==============================

    logic [STAGES-1:0] stage_q;

    // Moves one position per multiply dispatch and wraps to stage 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            stage_q <= {{(STAGES-1){1'b0}}, 1'b1};
        end else if (start_i && advance_i) begin
            stage_q <= {stage_q[STAGES-2:0], stage_q[STAGES-1]};
        end
    end

    //==============================
    // Stage slots
    //==============================

    logic [STAGES-1:0] slot_raw;
    logic [STAGES-1:0] slot_lat;
    logic [STAGES-1:0] slot_busy;

    for (genvar i = 0; i < STAGES; i++) begin : g_slot
        // Only the slot under the pointer sees the start
        exec_latency_tracker #(
            .LATENCY (sched_pkg::MUL_LATENCY)
        ) u_slot (
            .clk_i            (clk_i),
            .rst_n_i          (rst_n_i),
            .flush_i          (flush_i),
            .advance_i        (advance_i),
            .start_i          (start_i & stage_q[i]),
            .src0_i           (src0_i),
            .src1_i           (src1_i),
            .dest_i           (dest_i),
            .latency_i        (latency_i),
            .raw_hazard_o     (slot_raw[i]),
            .latency_hazard_o (slot_lat[i]),
            .busy_o           (slot_busy[i])
        );
    end

    // Any stage in flight counts
    assign raw_hazard_o     = |slot_raw;
    assign latency_hazard_o = |slot_lat;
    assign busy_o           = |slot_busy;

    a_stage_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot(stage_q)
    );

endmodule

`default_nettype wire

// File: source/load_tracker.sv
/*
 * Outstanding load tracking with busy flag, destination and RAW compare
 */

`timescale 1ns/1ps
`default_nettype none

module load_tracker (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                advance_i,
    input  logic                start_i,
    input  logic                ldu_idle_i,
    input  sched_pkg::reg_addr_t src0_i,
    input  sched_pkg::reg_addr_t src1_i,
    input  sched_pkg::reg_addr_t dest_i,
    output logic                raw_hazard_o,
    output logic                busy_o
);

    //==============================
    // Load state
    //==============================

    logic                 busy_q;
    sched_pkg::reg_addr_t dest_q;

    logic load;

    assign load = start_i & advance_i;

    // Set on dispatch, held until the load unit reports idle
    // A new load in the same cycle wins over the clear
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= 1'b0;
        end else if (load) begin
            busy_q <= 1'b1;
        end else if (advance_i && ldu_idle_i) begin
            busy_q <= 1'b0;
        end
    end

    // Destination of the load in flight
    always_ff @(posedge clk_i) begin
        if (load) begin
            dest_q <= dest_i;
        end
    end

    //==============================
    // Hazard compare
    //==============================

    assign busy_o = busy_q;

    // Same register rule as the latency slots
    assign raw_hazard_o = busy_q && (dest_q != '0) &&
                          ((src0_i == dest_q) || (src1_i == dest_q) || (dest_i == dest_q));

endmodule

`default_nettype wire

// File: source/issue_scheduler.sv
/*
 * In-order issue scheduler top with latency decode, divider slot,
 * hazard merge and issue and pipeline empty outputs
 */

`timescale 1ns/1ps
`default_nettype none

module issue_scheduler (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  stall_i,
    input  logic                  ldu_idle_i,
    input  sched_pkg::exec_unit_e unit_i,
    input  sched_pkg::reg_addr_t   src0_i,
    input  sched_pkg::reg_addr_t   src1_i,
    input  sched_pkg::reg_addr_t   dest_i,
    output logic                  issue_o,
    output logic                  pipeline_empty_o
);

    //==============================
    // Incoming latency
    //==============================

    sched_pkg::latency_t in_latency;

    // Unit latency plus the bypass stage
    // Load and empty slots never collide on write-back
    always_comb begin
        case (unit_i)
            sched_pkg::UNIT_ALU: in_latency = sched_pkg::latency_t'(
                sched_pkg::ALU_LATENCY + sched_pkg::BYPASS_STAGES);
            sched_pkg::UNIT_MUL: in_latency = sched_pkg::latency_t'(
                sched_pkg::MUL_LATENCY + sched_pkg::BYPASS_STAGES);
            sched_pkg::UNIT_DIV: in_latency = sched_pkg::latency_t'(
                sched_pkg::DIV_LATENCY + sched_pkg::BYPASS_STAGES);
            default:             in_latency = '0;
        endcase
    end

    //==============================
    // Tracker control
    //==============================

    logic advance;
    logic mul_start;
    logic div_start;
    logic ldu_start;

    // Stall freezes all trackers
    assign advance   = ~stall_i;
    assign mul_start = issue_o & (unit_i == sched_pkg::UNIT_MUL);
    assign div_start = issue_o & (unit_i == sched_pkg::UNIT_DIV);
    assign ldu_start = issue_o & (unit_i == sched_pkg::UNIT_LDU);

    logic mul_raw, mul_lat, mul_busy;
    logic div_raw, div_lat, div_busy;
    logic ldu_raw;

    // Six-stage pipelined multiplier
    mul_stage_tracker u_mul (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .advance_i        (advance),
        .start_i          (mul_start),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .dest_i           (dest_i),
        .latency_i        (in_latency),
        .raw_hazard_o     (mul_raw),
        .latency_hazard_o (mul_lat),
        .busy_o           (mul_busy)
    );

    // Sequential divider holds a single operation
    exec_latency_tracker #(
        .LATENCY (sched_pkg::DIV_LATENCY)
    ) u_div (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .advance_i        (advance),
        .start_i          (div_start),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .dest_i           (dest_i),
        .latency_i        (in_latency),
        .raw_hazard_o     (div_raw),
        .latency_hazard_o (div_lat),
        .busy_o           (div_busy)
    );

    // Pipeline empty follows the idle level of the load unit itself
    load_tracker u_ldu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .advance_i    (advance),
        .start_i      (ldu_start),
        .ldu_idle_i   (ldu_idle_i),
        .src0_i       (src0_i),
        .src1_i       (src1_i),
        .dest_i       (dest_i),
        .raw_hazard_o (ldu_raw),
        .busy_o       ()
    );

    //==============================
    // Hazard merge and outputs
    //==============================

    logic raw_hazard;
    logic lat_hazard;
    logic struct_hazard;

    assign raw_hazard    = mul_raw | div_raw | ldu_raw;
    assign lat_hazard    = mul_lat | div_lat;
    // Divider and load unit accept one operation at a time
    assign struct_hazard = ((unit_i == sched_pkg::UNIT_DIV) & div_busy) |
                           ((unit_i == sched_pkg::UNIT_LDU) & ~ldu_idle_i);

    assign issue_o = ~(raw_hazard | lat_hazard | struct_hazard);

    assign pipeline_empty_o = ~mul_busy & ~div_busy & ldu_idle_i;

    // A second divide never issues over a running one
    a_div_struct: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (unit_i == sched_pkg::UNIT_DIV) && div_busy |-> !issue_o
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/*
 * Testbench clock and synchronous reset generator
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD  = 5,
    parameter int unsigned RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release 1 ns after the last reset edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_cases.svh
/*
 * Stimulus and expected value table for the issue scheduler testbench
 */

`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// One table row, held for repeat_count cycles
typedef struct packed {
    sched_pkg::exec_unit_e unit;
    sched_pkg::reg_addr_t  src0;
    sched_pkg::reg_addr_t  src1;
    sched_pkg::reg_addr_t  dest;
    logic                  stall;
    logic                  flush;
    logic                  ldu_idle;
    int                    repeat_count;
    logic                  exp_issue;
    logic                  exp_empty;
} case_row_t;

case_row_t case_rows[$];
string     case_names[$];

task automatic add_row(input string name, input sched_pkg::exec_unit_e unit,
                       input int src0, input int src1, input int dest,
                       input int stall, input int flush, input int ldu_idle,
                       input int repeat_count, input int exp_issue, input int exp_empty);
    case_row_t row;
    row.unit         = unit;
    row.src0         = sched_pkg::reg_addr_t'(src0);
    row.src1         = sched_pkg::reg_addr_t'(src1);
    row.dest         = sched_pkg::reg_addr_t'(dest);
    row.stall        = (stall != 0);
    row.flush        = (flush != 0);
    row.ldu_idle     = (ldu_idle != 0);
    row.repeat_count = repeat_count;
    row.exp_issue    = (exp_issue != 0);
    row.exp_empty    = (exp_empty != 0);
    case_rows.push_back(row);
    case_names.push_back(name);
endtask

task automatic build_cases();
    // name, unit, src0, src1, dest, stall, flush, ldu_idle, repeats, issue, empty
    add_row("reset_alu", sched_pkg::UNIT_ALU, 1, 2, 3, 0, 0, 1, 1, 1, 1);
    // Multiply RAW while the counter runs 6 down to 1
    add_row("mul_r5", sched_pkg::UNIT_MUL, 1, 2, 5, 0, 0, 1, 1, 1, 1);
    add_row("alu_raw_r5_block", sched_pkg::UNIT_ALU, 5, 0, 6, 0, 0, 1, 6, 0, 0);
    add_row("alu_raw_r5_issue", sched_pkg::UNIT_ALU, 5, 0, 6, 0, 0, 1, 1, 1, 1);
    // Register 0 never blocks and latency 7 never matches a slot
    add_row("mul_r0", sched_pkg::UNIT_MUL, 0, 0, 0, 0, 0, 1, 1, 1, 1);
    add_row("mul_reads_r0", sched_pkg::UNIT_MUL, 0, 0, 0, 0, 0, 1, 5, 1, 0);
    add_row("drain_a", sched_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 6, 1, 0);
    // Write-back collision at slot counter 2
    add_row("mul_r8", sched_pkg::UNIT_MUL, 1, 2, 8, 0, 0, 1, 1, 1, 1);
    add_row("alu_wb_free_a", sched_pkg::UNIT_ALU, 1, 2, 3, 0, 0, 1, 4, 1, 0);
    add_row("alu_wb_collide", sched_pkg::UNIT_ALU, 1, 2, 3, 0, 0, 1, 1, 0, 0);
    add_row("alu_wb_free_b", sched_pkg::UNIT_ALU, 1, 2, 3, 0, 0, 1, 1, 1, 0);
    add_row("mul_b2b_a", sched_pkg::UNIT_MUL, 1, 2, 10, 0, 0, 1, 1, 1, 1);
    add_row("mul_b2b_b", sched_pkg::UNIT_MUL, 3, 4, 11, 0, 0, 1, 1, 1, 0);
    add_row("mul_b2b_c", sched_pkg::UNIT_MUL, 6, 7, 12, 0, 0, 1, 1, 1, 0);
    // First multiply still tracked in its own stage behind the two that followed
    add_row("mul_b2b_r10_held", sched_pkg::UNIT_NONE, 10, 0, 0, 0, 0, 1, 4, 0, 0);
    add_row("drain_b", sched_pkg::UNIT_NONE, 0, 0, 0, 0, 0, 1, 2, 1, 0);
    // Divider counter runs 36 down to 1
    add_row("div_r9", sched_pkg::UNIT_DIV, 1, 2, 9, 0, 0, 1, 1, 1, 1);
    add_row("div_held_a", sched_pkg::UNIT_DIV, 3, 4, 14, 0, 0, 1, 10, 0, 0);
    add_row("alu_beside_div", sched_pkg::UNIT_ALU, 1, 2, 3, 0, 0, 1, 24, 1, 0);
    add_row("alu_div_collide", sched_pkg::UNIT_ALU, 1, 2, 3, 0, 0, 1, 1, 0, 0);
    add_row("div_held_b", sched_pkg::UNIT_DIV, 3, 4, 14, 0, 0, 1, 1, 0, 0);
    add_row("div_second_issue", sched_pkg::UNIT_DIV, 3, 4, 14, 0, 0, 1, 1, 1, 1);
    // Flush drops the divide to r14
    add_row("flush_all", sched_pkg::UNIT_NONE, 0, 0, 0, 0, 1, 1, 1, 1, 0);
    add_row("raw_after_flush", sched_pkg::UNIT_ALU, 14, 0, 15, 0, 0, 1, 1, 1, 1);
    // Three stalled cycles stretch the block from 6 to 9
    add_row("mul_r5_b", sched_pkg::UNIT_MUL, 1, 2, 5, 0, 0, 1, 1, 1, 1);
    add_row("alu_raw_run_a", sched_pkg::UNIT_ALU, 5, 0, 6, 0, 0, 1, 2, 0, 0);
    add_row("alu_raw_stalled", sched_pkg::UNIT_ALU, 5, 0, 6, 1, 0, 1, 3, 0, 0);
    add_row("alu_raw_run_b", sched_pkg::UNIT_ALU, 5, 0, 6, 0, 0, 1, 4, 0, 0);
    add_row("alu_raw_stall_issue", sched_pkg::UNIT_ALU, 5, 0, 6, 0, 0, 1, 1, 1, 1);
    // Load unit busy and load RAW
    add_row("ldu_refused", sched_pkg::UNIT_LDU, 1, 2, 20, 0, 0, 0, 2, 0, 0);
    add_row("ldu_dispatch", sched_pkg::UNIT_LDU, 1, 2, 20, 0, 0, 1, 1, 1, 1);
    add_row("ld_reader_busy", sched_pkg::UNIT_ALU, 20, 0, 21, 0, 0, 0, 3, 0, 0);
    add_row("ld_reader_idle", sched_pkg::UNIT_ALU, 20, 0, 21, 0, 0, 1, 1, 0, 1);
    add_row("ld_reader_issue", sched_pkg::UNIT_ALU, 20, 0, 21, 0, 0, 1, 1, 1, 1);
endtask

`endif

// File: testbench/tb_issue_scheduler.sv
/*
 * Issue scheduler testbench top with DUT, table loop, compare tasks,
 * cycle timeout and summary
 */

`timescale 1ns/1ps
`default_nettype none

module tb_issue_scheduler;

    //==============================
    // DUT signals
    //==============================

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic                  stall;
    logic                  ldu_idle;
    sched_pkg::exec_unit_e unit;
    sched_pkg::reg_addr_t  src0;
    sched_pkg::reg_addr_t  src1;
    sched_pkg::reg_addr_t  dest;
    logic                  issue;
    logic                  pipeline_empty;

    int check_errors = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    `include "tb_cases.svh"

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    issue_scheduler dut0 (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .stall_i          (stall),
        .ldu_idle_i       (ldu_idle),
        .unit_i           (unit),
        .src0_i           (src0),
        .src1_i           (src1),
        .dest_i           (dest),
        .issue_o          (issue),
        .pipeline_empty_o (pipeline_empty)
    );

    //==============================
    // Compare and drive
    //==============================

    task automatic check_issue(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: issue_o expected %b, actual %b", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_empty(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: pipeline_empty_o expected %b, actual %b",
                     name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic drive_row(input case_row_t row);
        unit     = row.unit;
        src0     = row.src0;
        src1     = row.src1;
        dest     = row.dest;
        stall    = row.stall;
        flush    = row.flush;
        ldu_idle = row.ldu_idle;
    endtask

    // Ends the run if the table loop stops making progress
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //==============================
    // Table loop
    //==============================

    initial begin : main_seq
        int row_idx;
        int rep;
        int errors_before;
        int rows_passed;
        int rows_failed;
        int total_cycles;

        rows_passed  = 0;
        rows_failed  = 0;
        total_cycles = 0;
        unit         = sched_pkg::UNIT_NONE;
        src0         = '0;
        src1         = '0;
        dest         = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        ldu_idle     = 1'b1;

        build_cases();
        foreach (case_rows[i]) begin
            total_cycles += case_rows[i].repeat_count;
        end
        cycle_limit = total_cycles + 20;

        wait (rst_n == 1'b1);
        @(posedge clk);
        #1;

        for (row_idx = 0; row_idx < case_rows.size(); row_idx++) begin
            errors_before = check_errors;
            for (rep = 0; rep < case_rows[row_idx].repeat_count; rep++) begin
                drive_row(case_rows[row_idx]);
                // Sample 1 ns before the next edge
                #8;
                check_issue(case_names[row_idx], case_rows[row_idx].exp_issue, issue);
                check_empty(case_names[row_idx], case_rows[row_idx].exp_empty, pipeline_empty);
                @(posedge clk);
                #1;
            end
            if (check_errors == errors_before) begin
                rows_passed++;
                $display("row %0d %s ok", row_idx, case_names[row_idx]);
            end else begin
                rows_failed++;
                $display("row %0d %s mismatch", row_idx, case_names[row_idx]);
            end
        end

        $display("Rows passed: %0d, rows failed: %0d", rows_passed, rows_failed);
        if (rows_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: issue_scheduler.f
+incdir+testbench
source/sched_pkg.sv
source/exec_latency_tracker.sv
source/mul_stage_tracker.sv
source/load_tracker.sv
source/issue_scheduler.sv
testbench/tb_clock_gen.sv
testbench/tb_issue_scheduler.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_scheduler \
    -f issue_scheduler.f

output=$(./obj_dir/Vtb_issue_scheduler)
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
